//--- verilog/lruPkg.sv
package lruPkg;

  // ----------------------------------------
  // way and recency encoding
  // ----------------------------------------

  // the way count is tied to the 2-bit age with one age value per way.
  parameter int NUM_WAYS = 4;

  // way number inside a set.
  typedef logic [1:0] wayIdx;

  // recency of one way.
  // 0 is the most recently used, 3 the least recently used.
  typedef logic [1:0] lruAge;

  // ages of all ways of one set, indexed by way number.
  // the ages of a set always form a permutation of 0..3.
  typedef lruAge [NUM_WAYS-1:0] ageVec;

endpackage

//--- verilog/tagDirPkg.sv
package tagDirPkg;

  // ----------------------------------------
  // address split
  // ----------------------------------------

  parameter int ADDR_BITS = 32;

  // byte offset inside a 64-byte line.
  parameter int OFFSET_BITS = 6;

  // index bits stay inside the tag, so the tag width is fixed.
  parameter int TAG_BITS = ADDR_BITS - OFFSET_BITS;

  typedef logic [TAG_BITS-1:0] cacheTag;

  // tag part of a byte address.
  function automatic cacheTag addrTag(input logic [ADDR_BITS-1:0] addr);
    return addr[ADDR_BITS-1:OFFSET_BITS];
  endfunction

  // ----------------------------------------
  // lookup request and response
  // ----------------------------------------

  typedef struct packed {
    logic [ADDR_BITS-1:0] addr;
    logic                 fill;
  } dirRequest;

  typedef struct packed {
    logic          hit;
    lruPkg::wayIdx way;
    logic          evicted;
    cacheTag       evictedTag;
  } dirResponse;

  // ----------------------------------------
  // contents of one set
  // ----------------------------------------

  typedef struct packed {
    cacheTag [lruPkg::NUM_WAYS-1:0] tags;
    logic    [lruPkg::NUM_WAYS-1:0] valid;
    lruPkg::ageVec                  ages;
  } setState;

endpackage

//--- verilog/lruAgeUpdate.sv
`timescale 1ns/1ps

module lruAgeUpdate (
  input  lruPkg::ageVec ages,
  input  lruPkg::wayIdx touchedWay,
  output lruPkg::ageVec newAges
);

  import lruPkg::*;

  // old age of the way being touched.
  lruAge touchedAge;

  assign touchedAge = ages[touchedWay];

  // ----------------------------------------
  // one comparator and one incrementer per way
  // ----------------------------------------

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gWay
    logic  isTouched;
    logic  moreRecent;
    lruAge agePlusOne;

    assign isTouched  = (touchedWay == wayIdx'(w));

    // ways younger than the touched one move back by one.
    assign moreRecent = (ages[w] < touchedAge);
    assign agePlusOne = ages[w] + lruAge'(1);

    // touched way becomes the most recent.
    // older ways keep their age, so ages stay a permutation.
    assign newAges[w] = isTouched  ? lruAge'(0) :
                        moreRecent ? agePlusOne :
                                     ages[w];
  end

endmodule

//--- verilog/setStateArray.sv
`timescale 1ns/1ps

module setStateArray #(
  parameter int INDEX_BITS = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [INDEX_BITS-1:0] readIndex,
  output tagDirPkg::setState    readState,
  input  logic                  wrEnable,
  input  logic [INDEX_BITS-1:0] wrIndex,
  input  tagDirPkg::setState    wrState
);

  import lruPkg::*;
  import tagDirPkg::*;

  localparam int NUM_SETS = 1 << INDEX_BITS;

  // one entry per set.
  setState stateMem [NUM_SETS];

  // ----------------------------------------
  // write port
  // ----------------------------------------

  // reset empties every set and gives way k the age k.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        stateMem[s].valid <= '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
          stateMem[s].ages[w] <= lruAge'(w);
        end
      end
    end else if (wrEnable) begin
      stateMem[wrIndex] <= wrState;
    end
  end

  // ----------------------------------------
  // read port
  // ----------------------------------------

  // the read is combinational and a write shows up after the edge.
  assign readState = stateMem[readIndex];

endmodule

//--- verilog/lookupStage.sv
`timescale 1ns/1ps

module lookupStage #(
  parameter int INDEX_BITS = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  reqValid,
  input  tagDirPkg::dirRequest  req,
  output logic [INDEX_BITS-1:0] readIndex,
  input  tagDirPkg::setState    readState,
  input  logic                  wrEnable,
  input  logic [INDEX_BITS-1:0] wrIndex,
  input  tagDirPkg::setState    wrState,
  output logic                  stageValid,
  output tagDirPkg::dirRequest  stageReq,
  output tagDirPkg::setState    stageState,
  output logic                  stageHit,
  output lruPkg::wayIdx         stageWay
);

  import lruPkg::*;
  import tagDirPkg::*;

  setState              curState;
  cacheTag              reqTag;
  logic [NUM_WAYS-1:0]  wayMatch;
  logic                 anyHit;
  wayIdx                hitWay;
  logic                 anyFree;
  wayIdx                freeWay;
  wayIdx                oldestWay;
  wayIdx                chosenWay;

  // ----------------------------------------
  // set read with forwarding
  // ----------------------------------------

  assign readIndex = req.addr[OFFSET_BITS +: INDEX_BITS];

  // the request ahead of us may still be writing this set.
  assign curState = (wrEnable && (wrIndex == readIndex)) ? wrState : readState;

  // ----------------------------------------
  // tag compare
  // ----------------------------------------

  assign reqTag = addrTag(req.addr);

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gCmp
    assign wayMatch[w] = curState.valid[w] && (curState.tags[w] == reqTag);
  end

  assign anyHit = |wayMatch;

  // at most one way matches so a scan is enough.
  always_comb begin
    hitWay = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (wayMatch[w]) begin
        hitWay = wayIdx'(w);
      end
    end
  end

  // ----------------------------------------
  // victim choice
  // ----------------------------------------

  // lowest-numbered empty way wins.
  always_comb begin
    anyFree = 1'b0;
    freeWay = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!curState.valid[w]) begin
        anyFree = 1'b1;
        freeWay = wayIdx'(w);
      end
    end
  end

  // exactly one way carries age 3.
  always_comb begin
    oldestWay = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (curState.ages[w] == lruAge'(NUM_WAYS - 1)) begin
        oldestWay = wayIdx'(w);
      end
    end
  end

  assign chosenWay = anyHit  ? hitWay  :
                     anyFree ? freeWay :
                               oldestWay;

  // ----------------------------------------
  // stage register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      stageValid <= 1'b0;
    end else begin
      stageValid <= reqValid;
    end
  end

  always_ff @(posedge clk) begin
    if (reqValid) begin
      stageReq   <= req;
      stageState <= curState;
      stageHit   <= anyHit;
      stageWay   <= chosenWay;
    end
  end

endmodule

//--- verilog/updateStage.sv
`timescale 1ns/1ps

module updateStage #(
  parameter int INDEX_BITS = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  stageValid,
  input  tagDirPkg::dirRequest  stageReq,
  input  tagDirPkg::setState    stageState,
  input  logic                  stageHit,
  input  lruPkg::wayIdx         stageWay,
  output logic                  wrEnable,
  output logic [INDEX_BITS-1:0] wrIndex,
  output tagDirPkg::setState    wrState,
  output logic                  rspValid,
  output tagDirPkg::dirResponse rsp
);

  import lruPkg::*;
  import tagDirPkg::*;

  ageVec   newAges;
  logic    isFill;
  logic    victimValid;
  cacheTag victimTag;

  // ----------------------------------------
  // new recency
  // ----------------------------------------

  lruAgeUpdate i_lruAgeUpdate (
    .ages       (stageState.ages),
    .touchedWay (stageWay),
    .newAges    (newAges)
  );

  // ----------------------------------------
  // set write-back
  // ----------------------------------------

  // miss with fill installs the tag in the chosen way.
  assign isFill = !stageHit && stageReq.fill;

  // hits and fills write while a plain miss leaves the set alone.
  assign wrEnable = stageValid && (stageHit || stageReq.fill);
  assign wrIndex  = stageReq.addr[OFFSET_BITS +: INDEX_BITS];

  always_comb begin
    wrState      = stageState;
    wrState.ages = newAges;
    if (isFill) begin
      wrState.tags[stageWay]  = addrTag(stageReq.addr);
      wrState.valid[stageWay] = 1'b1;
    end
  end

  // ----------------------------------------
  // response
  // ----------------------------------------

  assign victimValid = stageState.valid[stageWay];
  assign victimTag   = stageState.tags[stageWay];

  always_ff @(posedge clk) begin
    if (reset) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= stageValid;
    end
  end

  // evicted tag reads as zero unless a valid line was replaced.
  always_ff @(posedge clk) begin
    if (stageValid) begin
      rsp.hit        <= stageHit;
      rsp.way        <= stageWay;
      rsp.evicted    <= isFill && victimValid;
      rsp.evictedTag <= (isFill && victimValid) ? victimTag : '0;
    end
  end

endmodule

//--- verilog/tagDirectory.sv
`timescale 1ns/1ps

module tagDirectory #(
  parameter int INDEX_BITS = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  reqValid,
  input  tagDirPkg::dirRequest  req,
  output logic                  rspValid,
  output tagDirPkg::dirResponse rsp
);

  import lruPkg::*;
  import tagDirPkg::*;

  // set read port.
  logic [INDEX_BITS-1:0] readIndex;
  setState               readState;

  // pending write that the lookup also sees for forwarding.
  logic                  wrEnable;
  logic [INDEX_BITS-1:0] wrIndex;
  setState               wrState;

  // lookup to update.
  logic                  stageValid;
  dirRequest             stageReq;
  setState               stageState;
  logic                  stageHit;
  wayIdx                 stageWay;

  // ----------------------------------------
  // stage 1 lookup
  // ----------------------------------------

  lookupStage #(
    .INDEX_BITS (INDEX_BITS)
  ) i_lookupStage (
    .clk        (clk),
    .reset      (reset),
    .reqValid   (reqValid),
    .req        (req),
    .readIndex  (readIndex),
    .readState  (readState),
    .wrEnable   (wrEnable),
    .wrIndex    (wrIndex),
    .wrState    (wrState),
    .stageValid (stageValid),
    .stageReq   (stageReq),
    .stageState (stageState),
    .stageHit   (stageHit),
    .stageWay   (stageWay)
  );

  // ----------------------------------------
  // stage 2 update and write-back
  // ----------------------------------------

  updateStage #(
    .INDEX_BITS (INDEX_BITS)
  ) i_updateStage (
    .clk        (clk),
    .reset      (reset),
    .stageValid (stageValid),
    .stageReq   (stageReq),
    .stageState (stageState),
    .stageHit   (stageHit),
    .stageWay   (stageWay),
    .wrEnable   (wrEnable),
    .wrIndex    (wrIndex),
    .wrState    (wrState),
    .rspValid   (rspValid),
    .rsp        (rsp)
  );

  setStateArray #(
    .INDEX_BITS (INDEX_BITS)
  ) i_setStateArray (
    .clk       (clk),
    .reset     (reset),
    .readIndex (readIndex),
    .readState (readState),
    .wrEnable  (wrEnable),
    .wrIndex   (wrIndex),
    .wrState   (wrState)
  );

endmodule

//--- dv/tagDirectory_assertions.sv
`timescale 1ns/1ps

module tagDirectory_assertions (
  input logic                  clk,
  input logic                  reset,
  input logic                  reqValid,
  input logic                  rspValid,
  input tagDirPkg::dirResponse rsp
);

  // ----------------------------------------
  // pipeline strobe timing
  // ----------------------------------------

  // each request gets one response two cycles later.
  assert property (@(posedge clk) disable iff (reset)
    rspValid == $past(reqValid, 2))
    else $error("rspValid does not follow reqValid by two cycles");

  // way field must be driven while the strobe is up.
  assert property (@(posedge clk) disable iff (reset)
    rspValid |-> !$isunknown(rsp.way))
    else $error("rsp.way unknown while rspValid is high");

  // a reset edge clears the response strobe.
  assert property (@(posedge clk)
    $past(reset) |-> !rspValid)
    else $error("rspValid high during reset");

endmodule

bind tagDirectory tagDirectory_assertions i_tagDirectory_assertions (
  .clk      (clk),
  .reset    (reset),
  .reqValid (reqValid),
  .rspValid (rspValid),
  .rsp      (rsp)
);

//--- dv/tagDirectoryTb.sv
`timescale 1ns/1ps

module tagDirectoryTb;

  import lruPkg::*;
  import tagDirPkg::*;

  localparam int INDEX_BITS = 4;
  localparam int NUM_SETS   = 1 << INDEX_BITS;

  logic       clk;
  logic       reset;
  logic       reqValid;
  dirRequest  req;
  logic       rspValid;
  dirResponse rsp;

  // reference model of the directory contents.
  cacheTag    modelTags  [NUM_SETS][NUM_WAYS];
  logic       modelValid [NUM_SETS][NUM_WAYS];
  int         modelAge   [NUM_SETS][NUM_WAYS];

  dirResponse expQ[$];
  int         reqCycleQ[$];
  int         cycleCount;

  tagDirectory #(
    .INDEX_BITS (INDEX_BITS)
  ) i_tagDirectory (
    .clk      (clk),
    .reset    (reset),
    .reqValid (reqValid),
    .req      (req),
    .rspValid (rspValid),
    .rsp      (rsp)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  function automatic logic [31:0] buildAddr(input int tagSel, input int setSel, input int offset);
    return (32'(tagSel) << (OFFSET_BITS + INDEX_BITS)) |
           (32'(setSel) << OFFSET_BITS) | 32'(offset);
  endfunction

  function automatic dirResponse predictResponse(input dirRequest r);
    int         setNum;
    int         way;
    int         oldAge;
    logic       hit;
    cacheTag    tag;
    dirResponse e;
    setNum = int'(r.addr[OFFSET_BITS +: INDEX_BITS]);
    tag    = r.addr[31:OFFSET_BITS];
    hit    = 1'b0;
    way    = -1;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (modelValid[setNum][w] && modelTags[setNum][w] == tag) begin
        hit = 1'b1;
        way = w;
      end
    end
    // miss goes to the lowest empty way, else to the age 3 way.
    if (!hit) begin
      for (int w = NUM_WAYS - 1; w >= 0; w--) begin
        if (!modelValid[setNum][w]) begin
          way = w;
        end
      end
    end
    if (way < 0) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (modelAge[setNum][w] == NUM_WAYS - 1) begin
          way = w;
        end
      end
    end
    e     = '0;
    e.hit = hit;
    e.way = wayIdx'(way);
    if (hit || r.fill) begin
      if (!hit) begin
        e.evicted = modelValid[setNum][way];
        if (modelValid[setNum][way]) begin
          e.evictedTag = modelTags[setNum][way];
        end
        modelTags[setNum][way]  = tag;
        modelValid[setNum][way] = 1'b1;
      end
      oldAge = modelAge[setNum][way];
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (w == way) begin
          modelAge[setNum][w] = 0;
        end else if (modelAge[setNum][w] < oldAge) begin
          modelAge[setNum][w] = modelAge[setNum][w] + 1;
        end
      end
    end
    return e;
  endfunction

  // ----------------------------------------
  // stimulus and checks
  // ----------------------------------------

  task automatic sendRequest(input int tagSel, input int setSel, input logic fill);
    dirRequest r;
    r.addr = buildAddr(tagSel, setSel, int'($urandom % 64));
    r.fill = fill;
    @(posedge clk);
    reqValid <= 1'b1;
    req      <= r;
    expQ.push_back(predictResponse(r));
  endtask

  task automatic idleCycle();
    @(posedge clk);
    reqValid <= 1'b0;
  endtask

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkResponse(input dirResponse got, input dirResponse exp);
    if (got.hit !== exp.hit) begin
      failRun($sformatf("mismatch at %0t: rsp.hit got %0b expected %0b",
                        $time, got.hit, exp.hit));
    end else if (got.way !== exp.way) begin
      failRun($sformatf("mismatch at %0t: rsp.way got %0d expected %0d",
                        $time, got.way, exp.way));
    end else if (got.evicted !== exp.evicted) begin
      failRun($sformatf("mismatch at %0t: rsp.evicted got %0b expected %0b",
                        $time, got.evicted, exp.evicted));
    end else if (got.evictedTag !== exp.evictedTag) begin
      failRun($sformatf("mismatch at %0t: rsp.evictedTag got %h expected %h",
                        $time, got.evictedTag, exp.evictedTag));
    end
  endtask

  task automatic checkLatency(input int reqCycle, input int rspCycle);
    if (rspCycle - reqCycle != 2) begin
      failRun($sformatf("mismatch at %0t: rspValid latency got %0d expected 2",
                        $time, rspCycle - reqCycle));
    end
  endtask

  // outputs are sampled half a cycle after the edge.
  always @(negedge clk) begin
    if (!reset) begin
      if (reqValid) begin
        reqCycleQ.push_back(cycleCount);
      end
      if (rspValid) begin
        if (expQ.size() == 0) begin
          failRun("response strobe arrived with no request outstanding");
        end else begin
          checkLatency(reqCycleQ.pop_front(), cycleCount);
          checkResponse(rsp, expQ.pop_front());
        end
      end
    end
  end

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    reqValid   = 1'b0;
    req        = '0;
    cycleCount = 0;
    void'($urandom(32'h8fabb619));
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        modelTags[s][w]  = '0;
        modelValid[s][w] = 1'b0;
        modelAge[s][w]   = w;
      end
    end
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    idleCycle();

    // back-to-back directed pass on set 5.
    for (int t = 1; t <= 4; t++) begin
      sendRequest(t, 5, 1'b1);
    end
    sendRequest(1, 5, 1'b0);
    sendRequest(2, 5, 1'b1);
    sendRequest(7, 5, 1'b1);
    sendRequest(3, 5, 1'b0);
    sendRequest(4, 5, 1'b0);
    sendRequest(8, 5, 1'b1);
    sendRequest(8, 5, 1'b1);
    idleCycle();

    // random traffic over a small tag pool and a few sets.
    for (int i = 0; i < 600; i++) begin
      if ($urandom % 8 == 0) begin
        idleCycle();
      end else begin
        sendRequest(1 + int'($urandom % 6), int'($urandom % 4), ($urandom % 4) != 0);
      end
    end
    idleCycle();

    for (int i = 0; i < 20 && expQ.size() != 0; i++) begin
      @(posedge clk);
    end
    if (expQ.size() != 0) begin
      failRun("timed out waiting for the last responses");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

//--- sim.f
verilog/lruPkg.sv
verilog/tagDirPkg.sv
verilog/lruAgeUpdate.sv
verilog/setStateArray.sv
verilog/lookupStage.sv
verilog/updateStage.sv
verilog/tagDirectory.sv
dv/tagDirectory_assertions.sv
dv/tagDirectoryTb.sv

//--- run.sh
#!/bin/sh
# Build and run the tag directory testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f sim.f \
  --top-module tagDirectoryTb \
  -o simv

status=0
./obj_dir/simv > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failing check"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
